//--- source/perfCounter_defines.svh
// Performance counter defines
`ifndef PERFCOUNTER_DEFINES_SVH
`define PERFCOUNTER_DEFINES_SVH

//////////////////////////////
// widths
//////////////////////////////

`define XLEN         32   // register width, counters are read as two halves
`define NUM_COUNTERS 16   // mcycle, unused slot, minstret, then hpm counters (max 32)

//////////////////////////////
// csr address map
//////////////////////////////

// machine-mode counters, writable
`define MHPMCOUNTER_BASE  12'hB00
`define MHPMCOUNTERH_BASE 12'hB80

// user-mode read-only shadows
`define HPMCOUNTER_BASE   12'hC00
`define HPMCOUNTERH_BASE  12'hC80

// time shadow of the external mtime, overlays user counter slot 1
`define TIME_ADR          12'hC01
`define TIMEH_ADR         12'hC81

//////////////////////////////
// privilege modes
//////////////////////////////

`define M_MODE 2'b11
`define S_MODE 2'b01
`define U_MODE 2'b00

`define S_SUPPORTED 1   // 1: scounteren gates user access too

`endif

//--- source/perfCounterPkg.sv
// Performance counter types
`include "perfCounter_defines.svh"

package perfCounterPkg;

  //////////////////////////////
  // plain vectors
  //////////////////////////////

  typedef logic [`XLEN-1:0]         xlenT;         // one csr data word
  typedef logic [11:0]              csrAdrT;       // csr address
  typedef logic [1:0]               privT;         // privilege mode
  typedef logic [`NUM_COUNTERS-1:0] counterMaskT;  // one bit per counter
  typedef logic [3:0]               instrClassT;   // bit 0 branch, 1 jump, 2 return

  // one half of every counter, low or high
  typedef xlenT [`NUM_COUNTERS-1:0] counterHalvesT;

  //////////////////////////////
  // grouped signals
  //////////////////////////////

  // retire info, M stage
  typedef struct packed {
    logic       instrValid;  // retired and not flushed
    instrClassT instrClass;
    logic       bpWrong;     // branch predictor wrong
    logic       csrWrite;
    logic       interrupt;
    logic       exception;
  } retireInfoT;

  // cache events from the memory side
  typedef struct packed {
    logic dCacheAccess;
    logic dCacheMiss;    // one cycle at start of miss
    logic iCacheAccess;
    logic iCacheMiss;
  } memEventsT;

  // csr port request, valid in M
  typedef struct packed {
    csrAdrT adr;
    logic   write;
    xlenT   writeVal;
    privT   priv;
  } csrReqT;

  // same-cycle csr response
  typedef struct packed {
    xlenT readVal;
    logic illegal;
  } csrRespT;

endpackage

//--- source/eventCapture.sv
// Retire event capture
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module eventCapture
  import perfCounterPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        stallE,
  input  logic        stallM,
  input  logic        flushM,
  input  logic        loadStallD,
  input  logic        storeStallD,
  input  retireInfoT  retire,
  input  memEventsT   mem,
  output counterMaskT events
);

  logic [1:0]  stallPairE;  // {store, load} in E
  logic [1:0]  stallPairM;  // {store, load} in M
  logic        loadStallM;
  logic        storeStallM;
  logic        iv;          // retired, not flushed
  logic [31:0] eventAll;    // full 32 slot map, trimmed below

  //////////////////////////////
  // stall flag pipeline D -> E -> M
  //////////////////////////////

  // E register holds while E is stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      stallPairE <= 2'b00;
    end else if (!stallE) begin
      stallPairE <= {storeStallD, loadStallD};
    end
  end

  // M register, flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || flushM) begin
      stallPairM <= 2'b00;
    end else if (!stallM) begin
      stallPairM <= stallPairE;
    end
  end

  assign loadStallM  = stallPairM[0];
  assign storeStallM = stallPairM[1];
  assign iv          = retire.instrValid;

  //////////////////////////////
  // event map
  //////////////////////////////

  always_comb begin
    eventAll     = '0;                     // unmapped slots never count
    eventAll[0]  = 1'b1;                   // mcycle
    eventAll[1]  = 1'b0;                   // slot 1 is time, no counter
    eventAll[2]  = iv;                     // minstret
    eventAll[3]  = retire.instrClass[0] & iv;  // branches
    // jumps that are not returns
    eventAll[4]  = retire.instrClass[1] & ~retire.instrClass[2] & iv;
    eventAll[5]  = retire.instrClass[2] & iv;  // returns
    eventAll[6]  = retire.bpWrong & iv;    // mispredicts
    eventAll[7]  = loadStallM & iv;        // load stalls
    eventAll[8]  = storeStallM & iv;       // store stalls
    eventAll[9]  = mem.dCacheAccess & iv;
    eventAll[10] = mem.dCacheMiss;         // miss can come without a retire
    eventAll[11] = mem.iCacheAccess & iv;
    eventAll[12] = mem.iCacheMiss;
    eventAll[13] = retire.csrWrite & iv;
    eventAll[14] = retire.interrupt;       // instrValid is low on a trap
    eventAll[15] = retire.exception;
  end

  assign events = eventAll[`NUM_COUNTERS-1:0];

endmodule

//--- source/counterBank.sv
// Counter bank
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module counterBank
  import perfCounterPkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  counterMaskT   events,    // per-counter event, M stage
  input  counterMaskT   inhibit,   // mcountinhibit
  input  csrReqT        csrReq,    // forwarded csr port
  output counterHalvesT lowRegs,
  output counterHalvesT highRegs
);

  //////////////////////////////
  // one 64-bit counter per slot
  //////////////////////////////

  for (genvar i = 0; i < `NUM_COUNTERS; i++) begin : gCounter
    // machine-mode addresses of this slot
    localparam csrAdrT LOW_ADR  = csrAdrT'(`MHPMCOUNTER_BASE + i);
    localparam csrAdrT HIGH_ADR = csrAdrT'(`MHPMCOUNTERH_BASE + i);

    xlenT               lowQ;
    xlenT               highQ;
    logic               tick;      // counts this edge
    logic [2*`XLEN-1:0] plusVal;   // full value after increment
    logic               wrLow;
    logic               wrHigh;

    assign tick    = events[i] & ~inhibit[i];
    assign plusVal = {highQ, lowQ} + {{(2*`XLEN-1){1'b0}}, tick};  // carry crosses halves

    // user shadows at 0xC00 are read-only, only mhpm addresses write
    assign wrLow  = csrReq.write && (csrReq.adr == LOW_ADR);
    assign wrHigh = csrReq.write && (csrReq.adr == HIGH_ADR);

    // a write replaces one half, the other half keeps the increment
    always_ff @(posedge clk) begin
      if (reset) begin
        lowQ  <= '0;
        highQ <= '0;
      end else begin
        lowQ  <= wrLow  ? csrReq.writeVal : plusVal[`XLEN-1:0];
        highQ <= wrHigh ? csrReq.writeVal : plusVal[2*`XLEN-1:`XLEN];
      end
    end

    assign lowRegs[i]  = lowQ;
    assign highRegs[i] = highQ;
  end

endmodule

//--- source/csrAccess.sv
// Counter CSR access
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module csrAccess
  import perfCounterPkg::*;
(
  input  csrReqT        csrReq,
  input  counterHalvesT lowRegs,
  input  counterHalvesT highRegs,
  input  counterMaskT   mcounteren,
  input  counterMaskT   scounteren,
  input  logic [63:0]   mtime,        // from the external timer
  output csrRespT       csrResp
);

  // index width into the counter arrays
  localparam int IDX_W = (`NUM_COUNTERS > 1) ? $clog2(`NUM_COUNTERS) : 1;

  logic [4:0]       counterNum;  // address low five bits
  logic [IDX_W-1:0] idx;
  logic [31:0]      mEnAll;      // enables widened to 32 slots
  logic [31:0]      sEnAll;
  logic             allowed;

  // true when adr falls in [base, base + NUM_COUNTERS)
  function automatic logic inRange(csrAdrT adr, csrAdrT base);
    return (adr >= base) && (adr < base + csrAdrT'(`NUM_COUNTERS));
  endfunction

  assign counterNum = csrReq.adr[4:0];
  assign idx        = counterNum[IDX_W-1:0];
  assign mEnAll     = 32'(mcounteren);  // slots past NUM_COUNTERS read as disabled
  assign sEnAll     = 32'(scounteren);

  //////////////////////////////
  // privilege check
  //////////////////////////////

  always_comb begin
    allowed = (csrReq.priv == `M_MODE) ||
              (mEnAll[counterNum] &&
               ((`S_SUPPORTED == 0) || (csrReq.priv == `S_MODE) || sEnAll[counterNum]));
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    csrResp.readVal = '0;
    csrResp.illegal = 1'b0;
    if (!allowed) begin
      csrResp.illegal = 1'b1;  // enable bit clear for this mode
    end else if (csrReq.adr == `TIME_ADR) begin
      csrResp.readVal = mtime[31:0];     // time overlays hpmcounter1
    end else if (csrReq.adr == `TIMEH_ADR) begin
      csrResp.readVal = mtime[63:32];
    end else if (inRange(csrReq.adr, `MHPMCOUNTER_BASE) ||
                 inRange(csrReq.adr, `HPMCOUNTER_BASE)) begin
      csrResp.readVal = lowRegs[idx];    // low half
    end else if (inRange(csrReq.adr, `MHPMCOUNTERH_BASE) ||
                 inRange(csrReq.adr, `HPMCOUNTERH_BASE)) begin
      csrResp.readVal = highRegs[idx];   // high half
    end else begin
      csrResp.illegal = 1'b1;  // no such counter csr
    end
  end

endmodule

//--- source/perfCounterTop.sv
// Performance monitor top
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module perfCounterTop
  import perfCounterPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  retireInfoT  retire,
  input  memEventsT   mem,
  input  logic        loadStallD,
  input  logic        storeStallD,
  input  logic        stallE,
  input  logic        stallM,
  input  logic        flushM,
  input  csrReqT      csrReq,
  input  counterMaskT mcountinhibit,
  input  counterMaskT mcounteren,
  input  counterMaskT scounteren,
  input  logic [63:0] mtime,
  output csrRespT     csrResp
);

  counterMaskT   events;    // capture -> count
  counterHalvesT lowRegs;   // count -> access
  counterHalvesT highRegs;

  //////////////////////////////
  // capture, count, access
  //////////////////////////////

  eventCapture eventCapture_i (
    .clk, .reset, .stallE, .stallM, .flushM,
    .loadStallD, .storeStallD, .retire, .mem, .events
  );

  counterBank counterBank_i (
    .clk, .reset, .events, .inhibit(mcountinhibit), .csrReq, .lowRegs, .highRegs
  );

  // read side, purely combinational
  csrAccess csrAccess_i (
    .csrReq, .lowRegs, .highRegs, .mcounteren, .scounteren, .mtime, .csrResp
  );

endmodule

//--- bench/perfCounter_properties.sv
// Counter bank and access assertions
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module perfCounterProperties
  import perfCounterPkg::*;
(
  input logic          clk,
  input logic          reset,
  input counterMaskT   inhibit,
  input csrReqT        csrReq,
  input csrRespT       csrResp,
  input counterHalvesT lowRegs,
  input counterHalvesT highRegs
);

  // illegal access returns nothing
  illegalZero: assert property (@(posedge clk) csrResp.illegal |-> csrResp.readVal == '0)
    else $error("illegal access returned a nonzero read value");

  // a reset cycle leaves every counter cleared
  resetClear: assert property (@(posedge clk) reset |=> (lowRegs == '0) && (highRegs == '0))
    else $error("counters not cleared after reset");

  for (genvar i = 0; i < `NUM_COUNTERS; i++) begin : gHold
    logic written;  // either half of slot i written this cycle
    assign written = csrReq.write &&
                     ((csrReq.adr == csrAdrT'(`MHPMCOUNTER_BASE + i)) ||
                      (csrReq.adr == csrAdrT'(`MHPMCOUNTERH_BASE + i)));

    holdInhibited: assert property (@(posedge clk) disable iff (reset)
      (inhibit[i] && !written) |=> {highRegs[i], lowRegs[i]} == $past({highRegs[i], lowRegs[i]}))
      else $error("inhibited counter %0d changed", i);
  end

endmodule

// watches the counter bank outputs and the access stage response
bind perfCounterTop perfCounterProperties props_i (
  .clk, .reset, .inhibit(mcountinhibit), .csrReq, .csrResp, .lowRegs, .highRegs
);

//--- bench/perfCounterChecker.sv
// Counter reference checker
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module perfCounterChecker
  import perfCounterPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  retireInfoT  retire,
  input  memEventsT   mem,
  input  logic        loadStallD,
  input  logic        storeStallD,
  input  logic        stallE,
  input  logic        stallM,
  input  logic        flushM,
  input  csrReqT      csrReq,
  input  counterMaskT mcountinhibit,
  input  counterMaskT mcounteren,
  input  counterMaskT scounteren,
  input  logic [63:0] mtime,
  input  csrRespT     csrResp,
  input  logic [2:0]  testId,
  input  logic        testDone,
  output logic        reportAck,
  output int          totalChecks,
  output int          totalErrors
);

  logic [63:0] model [`NUM_COUNTERS];  // full value per slot
  logic [1:0]  pipeE;                  // {store, load} stall flags in E
  logic [1:0]  pipeM;                  // same, in M
  int          testChecks;
  int          testErrors;

  function automatic string testName(logic [2:0] id);
    case (id)
      3'd1:    return "cycleCount";
      3'd2:    return "retireEvents";
      3'd3:    return "stallPipe";
      3'd4:    return "inhibitWrite";
      3'd5:    return "accessControl";
      default: return "unknown";
    endcase
  endfunction

  // counter events from the inputs of this cycle
  function automatic logic eventBit(int i);
    logic iv;
    iv = retire.instrValid;
    case (i)
      0:       return 1'b1;
      2:       return iv;
      3:       return iv & retire.instrClass[0];
      4:       return iv & retire.instrClass[1] & ~retire.instrClass[2];
      5:       return iv & retire.instrClass[2];
      6:       return iv & retire.bpWrong;
      7:       return iv & pipeM[0];
      8:       return iv & pipeM[1];
      9:       return iv & mem.dCacheAccess;
      10:      return mem.dCacheMiss;
      11:      return iv & mem.iCacheAccess;
      12:      return mem.iCacheMiss;
      13:      return iv & retire.csrWrite;
      14:      return retire.interrupt;
      15:      return retire.exception;
      default: return 1'b0;  // slot 1 and anything unmapped
    endcase
  endfunction

  // slot inside base's window, -1 when outside
  function automatic int slotOf(logic [11:0] base);
    int d;
    d = int'(csrReq.adr) - int'(base);
    return (d >= 0 && d < `NUM_COUNTERS) ? d : -1;
  endfunction

  task automatic expectResp(output xlenT val, output logic ill);
    logic [31:0] mEn;
    logic [31:0] sEn;
    logic [4:0]  num;
    logic        ok;
    int          lo;
    int          hi;
    mEn = '0;
    sEn = '0;
    mEn[`NUM_COUNTERS-1:0] = mcounteren;
    sEn[`NUM_COUNTERS-1:0] = scounteren;
    num = csrReq.adr[4:0];
    ok  = (csrReq.priv == `M_MODE) ||
          (mEn[num] && (!`S_SUPPORTED || csrReq.priv == `S_MODE || sEn[num]));
    lo  = slotOf(`MHPMCOUNTER_BASE);
    if (lo < 0) lo = slotOf(`HPMCOUNTER_BASE);
    hi  = slotOf(`MHPMCOUNTERH_BASE);
    if (hi < 0) hi = slotOf(`HPMCOUNTERH_BASE);
    val = '0;
    ill = 1'b1;
    if (ok) begin
      ill = 1'b0;
      if (csrReq.adr == `TIME_ADR) val = mtime[31:0];
      else if (csrReq.adr == `TIMEH_ADR) val = mtime[63:32];
      else if (lo >= 0) val = model[lo][31:0];
      else if (hi >= 0) val = model[hi][63:32];
      else ill = 1'b1;  // not a counter csr
    end
  endtask

  //////////////////////////////
  // compare, then step the model
  //////////////////////////////

  // negedge sees settled regs and inputs that hold until the next rising edge
  always @(negedge clk) begin : sampleEdge
    xlenT        expVal;
    logic        expIll;
    logic [63:0] nextVal;
    if (reset) begin
      for (int i = 0; i < `NUM_COUNTERS; i++) model[i] = '0;
      {pipeE, pipeM} = '0;
      {testChecks, testErrors, totalChecks, totalErrors} = '0;
      reportAck = 1'b0;
    end else begin
      expectResp(expVal, expIll);
      testChecks++;
      totalChecks++;
      if (csrResp.readVal !== expVal || csrResp.illegal !== expIll) begin
        testErrors++;
        totalErrors++;
        $display("[ERROR] %s adr %h: expected %h illegal %b, actual %h illegal %b",
                 testName(testId), csrReq.adr, expVal, expIll,
                 csrResp.readVal, csrResp.illegal);
      end
      for (int i = 0; i < `NUM_COUNTERS; i++) begin
        nextVal = model[i] + 64'(eventBit(i) & ~mcountinhibit[i]);
        if (csrReq.write && csrReq.adr == csrAdrT'(`MHPMCOUNTER_BASE + i))
          nextVal[31:0] = csrReq.writeVal;
        if (csrReq.write && csrReq.adr == csrAdrT'(`MHPMCOUNTERH_BASE + i))
          nextVal[63:32] = csrReq.writeVal;
        model[i] = nextVal;
      end
      if (flushM) pipeM = 2'b00;  // flush beats stall
      else if (!stallM) pipeM = pipeE;
      if (!stallE) pipeE = {storeStallD, loadStallD};
      if (testDone && !reportAck) begin
        $display("%-14s checks %0d errors %0d", testName(testId), testChecks, testErrors);
        {testChecks, testErrors} = '0;
        reportAck = 1'b1;
      end else if (!testDone) begin
        reportAck = 1'b0;
      end
    end
  end

endmodule

//--- bench/perfCounterTb.sv
// Performance monitor testbench
`include "perfCounter_defines.svh"
`timescale 1ns/10ps

module perfCounterTb
  import perfCounterPkg::*;
();

  localparam int ACK_TIMEOUT = 20;  // cycles for the checker to answer a report

  logic        clk;
  logic        reset;
  retireInfoT  retire;
  memEventsT   mem;
  logic        loadStallD;
  logic        storeStallD;
  logic        stallE;
  logic        stallM;
  logic        flushM;
  csrReqT      csrReq;
  counterMaskT mcountinhibit;
  counterMaskT mcounteren;
  counterMaskT scounteren;
  logic [63:0] mtime;
  csrRespT     csrResp;
  logic [2:0]  testId;     // which test is running, for the report lines
  logic        testDone;   // asks the checker for a per-test line
  logic        reportAck;
  int          totalChecks;
  int          totalErrors;
  int unsigned seedVal;

  perfCounterTop dut_i (
    .clk, .reset, .retire, .mem, .loadStallD, .storeStallD, .stallE, .stallM, .flushM,
    .csrReq, .mcountinhibit, .mcounteren, .scounteren, .mtime, .csrResp
  );

  perfCounterChecker checker_i (
    .clk, .reset, .retire, .mem, .loadStallD, .storeStallD, .stallE, .stallM, .flushM,
    .csrReq, .mcountinhibit, .mcounteren, .scounteren, .mtime, .csrResp,
    .testId, .testDone, .reportAck, .totalChecks, .totalErrors
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // hard limit on run time
  initial begin
    #(1_000_000);
    $display("simulation ran past its time limit");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic nextCycle();
    @(posedge clk);
    #2;  // inputs move just after the edge
  endtask

  // random retire and cache events, validPct sets how often instrValid is high
  task automatic randomRetire(input int validPct);
    logic [31:0] r;
    r = $urandom();
    retire.instrValid = ($urandom() % 100) < validPct;
    retire.instrClass = r[3:0];
    retire.bpWrong    = r[4];
    retire.csrWrite   = r[5];
    retire.interrupt  = r[6] & r[7] & r[8];  // traps are rare
    retire.exception  = r[9] & r[10];
    mem               = r[14:11];
  endtask

  function automatic csrAdrT counterAdr(csrAdrT base);
    return csrAdrT'(base + $urandom_range(`NUM_COUNTERS - 1));
  endfunction

  // wait until the checker's ack reaches level
  task automatic waitAck(input logic level, output logic ok);
    ok = 1'b0;
    for (int n = 0; n < ACK_TIMEOUT; n++) begin
      nextCycle();
      if (reportAck == level) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic finishTest();
    logic ok;
    testDone = 1'b1;
    waitAck(1'b1, ok);
    if (ok) begin
      testDone = 1'b0;
      waitAck(1'b0, ok);
    end
    if (!ok) begin
      $display("checker did not report test %0d in time", testId);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic cycleCount();
    testId = 3'd1;
    repeat (20) begin
      csrReq.adr = ($urandom() % 2) ? `MHPMCOUNTER_BASE : `MHPMCOUNTERH_BASE;
      nextCycle();
    end
    // low half at the wrap point, the following tick carries into high
    csrReq.adr      = `MHPMCOUNTER_BASE;
    csrReq.write    = 1'b1;
    csrReq.writeVal = 32'hFFFF_FFFF;
    nextCycle();
    csrReq.write = 1'b0;
    for (int n = 0; n < 10; n++) begin
      csrReq.adr = n[0] ? `MHPMCOUNTERH_BASE : `MHPMCOUNTER_BASE;
      nextCycle();
    end
    finishTest();
  endtask

  task automatic retireEvents();
    testId = 3'd2;
    repeat (300) begin
      randomRetire(50);
      csrReq.adr = counterAdr(($urandom() % 2) ? `MHPMCOUNTERH_BASE : `MHPMCOUNTER_BASE);
      nextCycle();
    end
    finishTest();
  endtask

  task automatic stallPipe();
    logic [31:0] r;
    testId = 3'd3;
    repeat (300) begin
      r = $urandom();
      randomRetire(70);
      loadStallD  = r[0];
      storeStallD = r[1];
      stallE      = (r[4:2] == 3'd0);
      stallM      = (r[7:5] == 3'd0);
      flushM      = (r[11:8] == 4'd0);
      csrReq.adr  = r[12] ? (r[13] ? 12'hB08 : 12'hB07) : (r[13] ? 12'hC08 : 12'hC07);
      nextCycle();
    end
    {loadStallD, storeStallD, stallE, stallM, flushM} = '0;
    finishTest();
  endtask

  task automatic inhibitWrite();
    logic [31:0] r;
    testId = 3'd4;
    for (int n = 0; n < 300; n++) begin
      r = $urandom();
      if (n % 20 == 0) mcountinhibit = counterMaskT'($urandom());  // new frozen set
      randomRetire(60);
      csrReq.adr      = counterAdr(r[3] ? `MHPMCOUNTERH_BASE : `MHPMCOUNTER_BASE);
      csrReq.write    = (r[1:0] == 2'b00);  // one cycle in four writes
      csrReq.writeVal = $urandom();
      nextCycle();
    end
    mcountinhibit = '0;
    csrReq.write  = 1'b0;
    finishTest();
  endtask

  task automatic accessControl();
    logic [31:0] r;
    testId = 3'd5;
    repeat (300) begin
      r = $urandom();
      randomRetire(50);
      csrReq.priv = r[1:0];  // includes the reserved code 2'b10
      mcounteren  = counterMaskT'($urandom());
      scounteren  = counterMaskT'($urandom());
      mtime       = {$urandom(), $urandom()};
      case (r[4:2])
        3'd0:    csrReq.adr = `TIME_ADR;
        3'd1:    csrReq.adr = `TIMEH_ADR;
        3'd2:    csrReq.adr = csrAdrT'(`MHPMCOUNTER_BASE + r[9:5]);  // slots 16..31 too
        3'd3:    csrReq.adr = csrAdrT'(`MHPMCOUNTERH_BASE + r[9:5]);
        3'd4:    csrReq.adr = csrAdrT'(`HPMCOUNTER_BASE + r[9:5]);
        3'd5:    csrReq.adr = csrAdrT'(`HPMCOUNTERH_BASE + r[9:5]);
        default: csrReq.adr = r[31:20];  // anywhere in csr space
      endcase
      nextCycle();
    end
    csrReq.priv = `M_MODE;
    mcounteren  = '1;
    finishTest();
  endtask

  initial begin
    seedVal       = $urandom(87);
    reset         = 1'b1;
    retire        = '0;
    mem           = '0;
    {loadStallD, storeStallD, stallE, stallM, flushM} = '0;
    csrReq        = '0;
    csrReq.priv   = `M_MODE;
    mcountinhibit = '0;
    mcounteren    = '1;
    scounteren    = '1;
    mtime         = 64'h0123_4567_89AB_CDEF;
    testId        = 3'd0;
    testDone      = 1'b0;
    repeat (8) nextCycle();
    reset = 1'b0;
    cycleCount();
    retireEvents();
    stallPipe();
    inhibitWrite();
    accessControl();
    $display("tests 5 checks %0d errors %0d", totalChecks, totalErrors);
    if (totalErrors == 0 && totalChecks > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+source
source/perfCounterPkg.sv
source/eventCapture.sv
source/counterBank.sv
source/csrAccess.sv
source/perfCounterTop.sv
bench/perfCounter_properties.sv
bench/perfCounterChecker.sv
bench/perfCounterTb.sv

//--- Makefile
# Verilator build and run of the performance monitor testbench
TOP = perfCounterTb

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o simv

run: build
	./obj_dir/simv | tee run.log
	grep -q "TEST RESULT: PASS" run.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean
